//--- source/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define WORD_WIDTH      32
`define REG_ADDR_WIDTH  5
`define LINK_REG        5'd31   // jal target register.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction fields.
`define OP          31:26
`define RS          25:21
`define RT          20:16
`define RD          15:11
`define SA          10:6
`define FUNC        5:0
`define IMM         15:0
`define INSTR_INDEX 25:0

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define OP_SPECIAL  6'b000000   // r-type, decoded by funct.
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_ADDIU    6'b001001
`define OP_ORI      6'b001101
`define OP_LUI      6'b001111
`define OP_LW       6'b100011
`define OP_SW       6'b101011

`define FUNC_SLL    6'b000000
`define FUNC_JR     6'b001000
`define FUNC_ADDU   6'b100001
`define FUNC_SUBU   6'b100011
`define FUNC_AND    6'b100100
`define FUNC_OR     6'b100101
`define FUNC_SLT    6'b101010

`endif

//--- source/mipsPkg.sv
`include "mips_consts.svh"

package mipsPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // three views of one instruction word.
    typedef struct packed {
        logic [5:0]                   op;
        logic [`REG_ADDR_WIDTH-1:0]   rs;
        logic [`REG_ADDR_WIDTH-1:0]   rt;
        logic [`REG_ADDR_WIDTH-1:0]   rd;
        logic [4:0]                   sa;
        logic [5:0]                   funct;
    } rTypeS;

    typedef struct packed {
        logic [5:0]                   op;
        logic [`REG_ADDR_WIDTH-1:0]   rs;
        logic [`REG_ADDR_WIDTH-1:0]   rt;
        logic [15:0]                  imm;
    } iTypeS;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] index;    // jump target, word aligned.
    } jTypeS;

    typedef union packed {
        rTypeS rType;
        iTypeS iType;
        jTypeS jType;
    } instrU;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control encodings.
    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluSll, aluLui
    } aluOpE;

    typedef enum logic [1:0] {npcSeq, npcBranch, npcJump, npcJumpReg} npcOpE;

    typedef enum logic [1:0] {srcAlu, srcMem, srcLink} regSrcE;

    typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstE;

endpackage

//--- source/decodeCtrlIf.sv
`timescale 1ns/100ps

interface decodeCtrlIf;
    logic            regWe;
    logic            memWe;
    logic            extOp;     // 1 = sign extend.
    mipsPkg::aluOpE  aluOp;
    logic            aluSrc1;   // shift amount instead of rs.
    logic            aluSrc2;   // immediate instead of rt.
    mipsPkg::regSrcE regSrc;
    mipsPkg::regDstE regDst;
    mipsPkg::npcOpE  npcOp;

    modport unit (output regWe, memWe, extOp, aluOp, aluSrc1, aluSrc2,
                  regSrc, regDst, npcOp);

    modport pc (input npcOp);

    modport stage (input regWe, memWe, extOp, aluOp, aluSrc1, aluSrc2,
                   regSrc, regDst);
endinterface

//--- source/registerFile.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module registerFile (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddr1,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddr2,
    input  logic                       writeEn,
    input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
    input  logic [`WORD_WIDTH-1:0]     writeData,
    output logic [`WORD_WIDTH-1:0]     readData1,
    output logic [`WORD_WIDTH-1:0]     readData2
);

    logic [`WORD_WIDTH-1:0] regs [2**`REG_ADDR_WIDTH];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // zero reg, then bypass of the write-back bus.
    function automatic logic [`WORD_WIDTH-1:0] readPort(
        input logic [`REG_ADDR_WIDTH-1:0] addr
    );
        if (addr == '0) return '0;
        if (writeEn && addr == writeAddr) return writeData;
        return regs[addr];
    endfunction

    always_comb readData1 = readPort(readAddr1);
    always_comb readData2 = readPort(readAddr2);

endmodule

//--- source/nextPc.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module nextPc (
    input  mipsPkg::instrU         instr,
    input  logic [`WORD_WIDTH-1:0] pcD,
    input  logic [`WORD_WIDTH-1:0] regData1,
    input  logic [`WORD_WIDTH-1:0] regData2,
    input  logic [`WORD_WIDTH-1:0] aluOutM,
    input  logic                   forwardAD,
    input  logic                   forwardBD,
    decodeCtrlIf.pc                ctrl,
    output logic [`WORD_WIDTH-1:0] npc,
    output logic [`WORD_WIDTH-1:0] linkAddr
);

    logic [`WORD_WIDTH-1:0] opA;
    logic [`WORD_WIDTH-1:0] opB;
    logic                   opEqual;
    logic [`WORD_WIDTH-1:0] pcPlus4;
    logic [`WORD_WIDTH-1:0] signImm;
    logic [`WORD_WIDTH-1:0] branchTarget;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // branch operands, bypassed from mem.
    assign opA = forwardAD ? aluOutM : regData1;
    assign opB = forwardBD ? aluOutM : regData2;
    assign opEqual = (opA == opB);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign pcPlus4 = pcD + `WORD_WIDTH'(4);
    assign signImm = {{(`WORD_WIDTH-16){instr.iType.imm[15]}}, instr.iType.imm};
    assign branchTarget = pcPlus4 + {signImm[`WORD_WIDTH-3:0], 2'b00};

    always_comb begin
        unique case (ctrl.npcOp)
            mipsPkg::npcBranch:  npc = opEqual ? branchTarget : pcPlus4;
            mipsPkg::npcJump:    npc = {pcPlus4[`WORD_WIDTH-1 -: 4], instr.jType.index, 2'b00};
            mipsPkg::npcJumpReg: npc = opA;
            default:             npc = pcPlus4;
        endcase
    end

    assign linkAddr = pcD + `WORD_WIDTH'(8);   // skips the delay slot.

endmodule

//--- source/controlUnit.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module controlUnit (
    input  logic           rstN,
    input  mipsPkg::instrU instr,
    decodeCtrlIf.unit      ctrl
);

    logic [5:0] op;
    logic [5:0] funct;

    assign op    = instr.rType.op;
    assign funct = instr.rType.funct;

    always_comb begin
        // no-op word, also held during reset.
        ctrl.regWe   = 1'b0;
        ctrl.memWe   = 1'b0;
        ctrl.extOp   = 1'b1;
        ctrl.aluOp   = mipsPkg::aluAdd;
        ctrl.aluSrc1 = 1'b0;
        ctrl.aluSrc2 = 1'b0;
        ctrl.regSrc  = mipsPkg::srcAlu;
        ctrl.regDst  = mipsPkg::dstRt;
        ctrl.npcOp   = mipsPkg::npcSeq;

        if (rstN) begin
            case (op)
                `OP_SPECIAL: begin
                    ctrl.regDst = mipsPkg::dstRd;
                    ctrl.regWe  = 1'b1;
                    case (funct)
                        `FUNC_ADDU: ctrl.aluOp = mipsPkg::aluAdd;
                        `FUNC_SUBU: ctrl.aluOp = mipsPkg::aluSub;
                        `FUNC_AND:  ctrl.aluOp = mipsPkg::aluAnd;
                        `FUNC_OR:   ctrl.aluOp = mipsPkg::aluOr;
                        `FUNC_SLT:  ctrl.aluOp = mipsPkg::aluSlt;
                        `FUNC_SLL: begin
                            ctrl.aluOp   = mipsPkg::aluSll;
                            ctrl.aluSrc1 = 1'b1;
                        end
                        `FUNC_JR: begin
                            ctrl.regWe = 1'b0;
                            ctrl.npcOp = mipsPkg::npcJumpReg;
                        end
                        default: ctrl.regWe = 1'b0;   // unknown funct.
                    endcase
                end
                `OP_ADDIU: begin
                    ctrl.regWe   = 1'b1;
                    ctrl.aluSrc2 = 1'b1;
                end
                `OP_ORI: begin
                    ctrl.regWe   = 1'b1;
                    ctrl.aluSrc2 = 1'b1;
                    ctrl.extOp   = 1'b0;
                    ctrl.aluOp   = mipsPkg::aluOr;
                end
                `OP_LUI: begin
                    ctrl.regWe   = 1'b1;
                    ctrl.aluSrc2 = 1'b1;
                    ctrl.aluOp   = mipsPkg::aluLui;
                end
                `OP_LW: begin
                    ctrl.regWe   = 1'b1;
                    ctrl.aluSrc2 = 1'b1;
                    ctrl.regSrc  = mipsPkg::srcMem;
                end
                `OP_SW: begin
                    ctrl.memWe   = 1'b1;
                    ctrl.aluSrc2 = 1'b1;
                end
                `OP_BEQ: ctrl.npcOp = mipsPkg::npcBranch;
                `OP_J:   ctrl.npcOp = mipsPkg::npcJump;
                `OP_JAL: begin
                    ctrl.regWe  = 1'b1;
                    ctrl.regSrc = mipsPkg::srcLink;
                    ctrl.regDst = mipsPkg::dstRa;
                    ctrl.npcOp  = mipsPkg::npcJump;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- source/decodeStage.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module decodeStage (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [`WORD_WIDTH-1:0]     instrD,
    input  logic [`WORD_WIDTH-1:0]     pcD,
    input  logic                       regWeW,
    input  logic [`REG_ADDR_WIDTH-1:0] writeRegAddrW,
    input  logic [`WORD_WIDTH-1:0]     wbOut,
    input  logic [`WORD_WIDTH-1:0]     aluOutM,
    input  logic                       forwardAD,
    input  logic                       forwardBD,
    output logic [`WORD_WIDTH-1:0]     npc,
    output logic [`WORD_WIDTH-1:0]     linkAddrD,
    output logic                       regWeD,
    output logic                       memWeD,
    output logic                       extOpD,
    output logic                       aluSrc1D,
    output logic                       aluSrc2D,
    output mipsPkg::aluOpE             aluOpD,
    output mipsPkg::regSrcE            regSrcD,
    output mipsPkg::regDstE            regDstD,
    output mipsPkg::npcOpE             npcOpD,
    output logic [`WORD_WIDTH-1:0]     readData1D,
    output logic [`WORD_WIDTH-1:0]     readData2D,
    output logic [`REG_ADDR_WIDTH-1:0] rsD,
    output logic [`REG_ADDR_WIDTH-1:0] rtD,
    output logic [`REG_ADDR_WIDTH-1:0] rdD,
    output logic [4:0]                 shamtD,
    output logic [15:0]                imm16D
);

    mipsPkg::instrU instr;
    decodeCtrlIf    ctrlBus ();

    assign instr  = instrD;
    assign rsD    = instr.rType.rs;
    assign rtD    = instr.rType.rt;
    assign rdD    = instr.rType.rd;
    assign shamtD = instr.rType.sa;
    assign imm16D = instr.iType.imm;

    registerFile regFile (
        .clk(clk), .rstN(rstN),
        .readAddr1(instr.rType.rs), .readAddr2(instr.rType.rt),
        .writeEn(regWeW), .writeAddr(writeRegAddrW), .writeData(wbOut),
        .readData1(readData1D), .readData2(readData2D)
    );

    nextPc pcUnit (
        .instr(instr), .pcD(pcD),
        .regData1(readData1D), .regData2(readData2D),
        .aluOutM(aluOutM), .forwardAD(forwardAD), .forwardBD(forwardBD),
        .ctrl(ctrlBus.pc), .npc(npc), .linkAddr(linkAddrD)
    );

    controlUnit ctrlUnit (.rstN(rstN), .instr(instr), .ctrl(ctrlBus.unit));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control word out to plain ports.
    assign regWeD   = ctrlBus.regWe;
    assign memWeD   = ctrlBus.memWe;
    assign extOpD   = ctrlBus.extOp;
    assign aluSrc1D = ctrlBus.aluSrc1;
    assign aluSrc2D = ctrlBus.aluSrc2;
    assign aluOpD   = ctrlBus.aluOp;
    assign regSrcD  = ctrlBus.regSrc;
    assign regDstD  = ctrlBus.regDst;
    assign npcOpD   = ctrlBus.npcOp;

endmodule

//--- verification/decodeStage_asserts.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module decodeStageAsserts (
    input logic                   clk,
    input logic                   rstN,
    input logic                   regWeD,
    input logic                   memWeD,
    input logic [`WORD_WIDTH-1:0] npc,
    input logic [`WORD_WIDTH-1:0] pcD,
    input mipsPkg::npcOpE         npcOpD
);

    int failCount = 0;

    // a store never writes a register.
    assert property (@(posedge clk) !(regWeD && memWeD))
        else begin
            failCount++;
            $error("regWeD and memWeD both high");
        end

    assert property (@(posedge clk) !rstN |-> (!regWeD && !memWeD))
        else begin
            failCount++;
            $error("write enable high during reset");
        end

    // targets keep word alignment, jr takes the register as is.
    assert property (@(posedge clk) disable iff (!rstN)
        (npcOpD != mipsPkg::npcJumpReg) |-> (npc[1:0] == pcD[1:0]))
        else begin
            failCount++;
            $error("npc alignment differs from pcD");
        end

endmodule

bind decodeStage decodeStageAsserts propChecks (
    .clk(clk), .rstN(rstN), .regWeD(regWeD), .memWeD(memWeD),
    .npc(npc), .pcD(pcD), .npcOpD(npcOpD)
);

//--- verification/decodeStageTb.sv
`timescale 1ns/100ps
`include "mips_consts.svh"

module decodeStageTb;

    logic clk = 1'b0;
    logic rstN;
    logic [`WORD_WIDTH-1:0] instrD, pcD, wbOut, aluOutM;
    logic regWeW, forwardAD, forwardBD;
    logic [`REG_ADDR_WIDTH-1:0] writeRegAddrW;
    logic [`WORD_WIDTH-1:0] npc, linkAddrD, readData1D, readData2D;
    logic regWeD, memWeD, extOpD, aluSrc1D, aluSrc2D;
    mipsPkg::aluOpE aluOpD;
    mipsPkg::regSrcE regSrcD;
    mipsPkg::regDstE regDstD;
    mipsPkg::npcOpE npcOpD;
    logic [`REG_ADDR_WIDTH-1:0] rsD, rtD, rdD;
    logic [4:0] shamtD;
    logic [15:0] imm16D;
    logic [`WORD_WIDTH-1:0] model [32];   // expected register contents.

    decodeStage UUT (.*);

    always #2 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic failRun(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic reportError(input string sig, input string got, input string exp);
        failRun($sformatf("error at %0.1f ns: %s is %s, expected %s",
                          $realtime, sig, got, exp));
    endtask

    task automatic compareWord(input string sig, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) reportError(sig, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic compareReg(input string sig, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) reportError(sig, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask

    task automatic compareBit(input string sig, input logic got, input logic exp);
        if (got !== exp) reportError(sig, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    task automatic compareCtrl(input string name, input logic we, mwe, ext, s1, s2,
                               input mipsPkg::aluOpE alu, input mipsPkg::regSrcE src,
                               input mipsPkg::regDstE dst, input mipsPkg::npcOpE nop);
        compareBit({name, " regWeD"}, regWeD, we);
        compareBit({name, " memWeD"}, memWeD, mwe);
        compareBit({name, " extOpD"}, extOpD, ext);
        compareBit({name, " aluSrc1D"}, aluSrc1D, s1);
        compareBit({name, " aluSrc2D"}, aluSrc2D, s2);
        if (aluOpD !== alu) reportError({name, " aluOpD"}, aluOpD.name(), alu.name());
        if (regSrcD !== src) reportError({name, " regSrcD"}, regSrcD.name(), src.name());
        if (regDstD !== dst) reportError({name, " regDstD"}, regDstD.name(), dst.name());
        if (npcOpD !== nop) reportError({name, " npcOpD"}, npcOpD.name(), nop.name());
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] rInstr(input logic [4:0] rs, rt, rd, sa,
                                           input logic [5:0] funct);
        return {`OP_SPECIAL, rs, rt, rd, sa, funct};
    endfunction

    function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rs, rt,
                                           input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jInstr(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    task automatic driveEdge();
        @(posedge clk);
        #0.5;
    endtask

    task automatic sampleMid();
        @(negedge clk);
    endtask

    task automatic driveDecode(input logic [31:0] word, pc, input logic fa, fb,
                               input logic [31:0] aluOut);
        driveEdge();
        instrD = word;
        pcD = pc;
        forwardAD = fa;
        forwardBD = fb;
        aluOutM = aluOut;
        sampleMid();
    endtask

    // write through the write-back bus and check the bypass.
    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        driveEdge();
        regWeW = 1'b1;
        writeRegAddrW = addr;
        wbOut = data;
        instrD = rInstr(addr, 5'd0, 5'd0, 5'd0, `FUNC_ADDU);
        sampleMid();
        compareWord("readData1D", readData1D, (addr == 0) ? 32'h0 : data);
        driveEdge();
        regWeW = 1'b0;
        if (addr != 0) model[addr] = data;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic testReset();
        bit active = 1'b0;
        for (int i = 0; i < 10; i++) begin
            sampleMid();
            compareCtrl("reset", 0, 0, 1, 0, 0, mipsPkg::aluAdd, mipsPkg::srcAlu,
                        mipsPkg::dstRt, mipsPkg::npcSeq);
        end
        driveEdge();
        rstN = 1'b1;
        for (int t = 0; t < 4 && !active; t++) begin
            sampleMid();
            active = regWeD;
        end
        if (!active) failRun("control did not leave reset within 4 cycles");
        for (int i = 0; i < 32; i++) begin
            driveDecode(rInstr(i, 31 - i, 5'd1, 5'd0, `FUNC_ADDU), 32'h0, 0, 0, 32'h0);
            compareWord("readData1D", readData1D, 32'h0);
            compareWord("readData2D", readData2D, 32'h0);
        end
    endtask

    task automatic testRegisterFile();
        logic [4:0] addr;
        logic [4:0] other;
        for (int n = 0; n < 40; n++) begin
            addr = $urandom % 32;
            writeReg(addr, $urandom);
            other = $urandom % 32;
            driveDecode(rInstr(addr, other, 5'd0, 5'd0, `FUNC_ADDU), 32'h0, 0, 0, 32'h0);
            compareWord("readData1D", readData1D, model[addr]);
            compareWord("readData2D", readData2D, model[other]);
        end
        writeReg(5'd0, 32'hdead_beef);
        driveDecode(rInstr(5'd0, 5'd0, 5'd0, 5'd0, `FUNC_ADDU), 32'h0, 0, 0, 32'h0);
        compareWord("readData1D", readData1D, 32'h0);
    endtask

    task automatic checkDecode(input string name, input logic [31:0] word,
                               input logic we, mwe, ext, s1, s2,
                               input mipsPkg::aluOpE alu, input mipsPkg::regSrcE src,
                               input mipsPkg::regDstE dst, input mipsPkg::npcOpE nop);
        driveDecode(word, 32'h0040_0000, 0, 0, 32'h0);
        compareCtrl(name, we, mwe, ext, s1, s2, alu, src, dst, nop);
        compareReg("rsD", rsD, word[`RS]);
        compareReg("rtD", rtD, word[`RT]);
        compareReg("rdD", rdD, word[`RD]);
        compareReg("shamtD", shamtD, word[`SA]);
        compareWord("imm16D", {16'h0, imm16D}, {16'h0, word[`IMM]});
    endtask

    task automatic testControl();
        checkDecode("addu", rInstr(1, 2, 3, 0, `FUNC_ADDU), 1, 0, 1, 0, 0,
                    mipsPkg::aluAdd, mipsPkg::srcAlu, mipsPkg::dstRd, mipsPkg::npcSeq);
        checkDecode("subu", rInstr(4, 5, 6, 0, `FUNC_SUBU), 1, 0, 1, 0, 0,
                    mipsPkg::aluSub, mipsPkg::srcAlu, mipsPkg::dstRd, mipsPkg::npcSeq);
        checkDecode("and", rInstr(7, 8, 9, 0, `FUNC_AND), 1, 0, 1, 0, 0,
                    mipsPkg::aluAnd, mipsPkg::srcAlu, mipsPkg::dstRd, mipsPkg::npcSeq);
        checkDecode("or", rInstr(10, 11, 12, 0, `FUNC_OR), 1, 0, 1, 0, 0,
                    mipsPkg::aluOr, mipsPkg::srcAlu, mipsPkg::dstRd, mipsPkg::npcSeq);
        checkDecode("slt", rInstr(13, 14, 15, 0, `FUNC_SLT), 1, 0, 1, 0, 0,
                    mipsPkg::aluSlt, mipsPkg::srcAlu, mipsPkg::dstRd, mipsPkg::npcSeq);
        checkDecode("sll", rInstr(0, 16, 17, 5'd7, `FUNC_SLL), 1, 0, 1, 1, 0,
                    mipsPkg::aluSll, mipsPkg::srcAlu, mipsPkg::dstRd, mipsPkg::npcSeq);
        checkDecode("jr", rInstr(18, 0, 0, 0, `FUNC_JR), 0, 0, 1, 0, 0,
                    mipsPkg::aluAdd, mipsPkg::srcAlu, mipsPkg::dstRd, mipsPkg::npcJumpReg);
        checkDecode("addiu", iInstr(`OP_ADDIU, 19, 20, 16'h8001), 1, 0, 1, 0, 1,
                    mipsPkg::aluAdd, mipsPkg::srcAlu, mipsPkg::dstRt, mipsPkg::npcSeq);
        checkDecode("ori", iInstr(`OP_ORI, 21, 22, 16'hf0f0), 1, 0, 0, 0, 1,
                    mipsPkg::aluOr, mipsPkg::srcAlu, mipsPkg::dstRt, mipsPkg::npcSeq);
        checkDecode("lui", iInstr(`OP_LUI, 0, 23, 16'h1234), 1, 0, 1, 0, 1,
                    mipsPkg::aluLui, mipsPkg::srcAlu, mipsPkg::dstRt, mipsPkg::npcSeq);
        checkDecode("lw", iInstr(`OP_LW, 24, 25, 16'h0010), 1, 0, 1, 0, 1,
                    mipsPkg::aluAdd, mipsPkg::srcMem, mipsPkg::dstRt, mipsPkg::npcSeq);
        checkDecode("sw", iInstr(`OP_SW, 26, 27, 16'hfffc), 0, 1, 1, 0, 1,
                    mipsPkg::aluAdd, mipsPkg::srcAlu, mipsPkg::dstRt, mipsPkg::npcSeq);
        checkDecode("beq", iInstr(`OP_BEQ, 28, 29, 16'h0004), 0, 0, 1, 0, 0,
                    mipsPkg::aluAdd, mipsPkg::srcAlu, mipsPkg::dstRt, mipsPkg::npcBranch);
        checkDecode("j", jInstr(`OP_J, 26'h0abcdef), 0, 0, 1, 0, 0,
                    mipsPkg::aluAdd, mipsPkg::srcAlu, mipsPkg::dstRt, mipsPkg::npcJump);
        checkDecode("jal", jInstr(`OP_JAL, 26'h0123456), 1, 0, 1, 0, 0,
                    mipsPkg::aluAdd, mipsPkg::srcLink, mipsPkg::dstRa, mipsPkg::npcJump);
        checkDecode("unknown", iInstr(6'b111111, 1, 2, 16'h5555), 0, 0, 1, 0, 0,
                    mipsPkg::aluAdd, mipsPkg::srcAlu, mipsPkg::dstRt, mipsPkg::npcSeq);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic branchCase(input logic [4:0] rs, rt, input logic [15:0] imm,
                              input logic fa, fb, input logic [31:0] aluOut);
        logic [31:0] pc;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] expNpc;
        pc = 32'h0040_1000;
        opA = fa ? aluOut : model[rs];
        opB = fb ? aluOut : model[rt];
        expNpc = pc + 4;
        if (opA == opB) expNpc = pc + 4 + ({{16{imm[15]}}, imm} << 2);
        driveDecode(iInstr(`OP_BEQ, rs, rt, imm), pc, fa, fb, aluOut);
        compareWord("npc", npc, expNpc);
    endtask

    task automatic testBranches();
        writeReg(5'd5, 32'h0000_1234);
        writeReg(5'd6, 32'h0000_1234);
        writeReg(5'd7, 32'h0000_0999);
        branchCase(5, 6, 16'h0010, 0, 0, 32'h0);
        branchCase(5, 7, 16'h0010, 0, 0, 32'h0);
        branchCase(5, 6, 16'hfff0, 0, 0, 32'h0);   // backwards.
        branchCase(7, 5, 16'h0020, 1, 0, 32'h0000_1234);
        branchCase(5, 7, 16'hff00, 0, 1, 32'h0000_1234);
        branchCase(5, 6, 16'h0008, 1, 0, 32'h0000_0001);   // equal regs, forwarded A differs.
        branchCase(5, 6, 16'h0008, 0, 1, 32'h0000_0001);
    endtask

    task automatic testJumps();
        logic [31:0] pc;
        logic [31:0] pcNext;
        pc = 32'h8fff_fffc;   // pc + 4 crosses into the next 256 MB region.
        pcNext = pc + 4;
        driveDecode(jInstr(`OP_J, 26'h0123456), pc, 0, 0, 32'h0);
        compareWord("npc", npc, {pcNext[31:28], 26'h0123456, 2'b00});
        driveDecode(jInstr(`OP_JAL, 26'h3fffffc), pc, 0, 0, 32'h0);
        compareWord("npc", npc, {pcNext[31:28], 26'h3fffffc, 2'b00});
        compareWord("linkAddrD", linkAddrD, pc + 8);
        compareCtrl("jal", 1, 0, 1, 0, 0, mipsPkg::aluAdd, mipsPkg::srcLink,
                    mipsPkg::dstRa, mipsPkg::npcJump);
        driveDecode(rInstr(5, 0, 0, 0, `FUNC_JR), pc, 0, 0, 32'h0);
        compareWord("npc", npc, model[5]);
        driveDecode(rInstr(5, 0, 0, 0, `FUNC_JR), pc, 1, 0, 32'h0040_2000);
        compareWord("npc", npc, 32'h0040_2000);
    endtask

    initial begin
        #50000;
        failRun("simulation did not finish within 50 us");
    end

    initial begin
        void'($urandom(32'hff25));
        rstN = 1'b0;
        instrD = rInstr(1, 2, 3, 0, `FUNC_ADDU);
        pcD = 32'h0;
        regWeW = 1'b0;
        writeRegAddrW = '0;
        wbOut = '0;
        aluOutM = '0;
        forwardAD = 1'b0;
        forwardBD = 1'b0;
        for (int i = 0; i < 32; i++) model[i] = '0;

        testReset();
        testRegisterFile();
        testControl();
        testBranches();
        testJumps();

        if (UUT.propChecks.failCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+source
source/mipsPkg.sv
source/decodeCtrlIf.sv
source/registerFile.sv
source/nextPc.sv
source/controlUnit.sv
source/decodeStage.sv
verification/decodeStage_asserts.sv
verification/decodeStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the decodeStage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f src.f --top-module decodeStageTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/VdecodeStageTb > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
    exit 1
fi

if [ $simStatus -ne 0 ]; then
    echo "simulator returned status $simStatus"
    exit 1
fi

exit 0
